// ==== include/barrel_consts.svh ====
`ifndef BARREL_CONSTS_SVH
`define BARREL_CONSTS_SVH

// Core geometry
`define NUM_CTX      8
`define CTX_BITS     3
`define XLEN         32
`define NUM_REGS     32
`define REG_BITS     5

// Boot address of context n is n << CTX_PC_SHIFT
`define CTX_PC_SHIFT 12

// ORI r0,r0,0 used as the pipeline bubble
`define NOP_WORD     32'h1000_0000

`endif

// ==== rtl/isa_pkg.sv ====
`include "barrel_consts.svh"
`default_nettype none

package isa_pkg;

	typedef enum logic [5:0] {
		RR   = 6'd0,
		ADDI = 6'd1,
		SUBI = 6'd2,
		ANDI = 6'd3,
		ORI  = 6'd4,
		XORI = 6'd5,
		CMPI = 6'd6,
		JMP  = 6'd7,
		BCC  = 6'd8,
		LW   = 6'd9,
		SW   = 6'd10
	} opcode_e;

	// Function field of RR instructions
	typedef enum logic [5:0] {
		ADD = 6'd0,
		SUB = 6'd1,
		AND = 6'd2,
		OR  = 6'd3,
		XOR = 6'd4,
		CMP = 6'd5
	} funct_e;

	// Branch conditions carried in the low bits of the ra field
	typedef enum logic [3:0] {
		BRA  = 4'd0,
		BEQ  = 4'd1,
		BNE  = 4'd2,
		BGTU = 4'd3,
		BLEU = 4'd4,
		BLTU = 4'd5,
		BGEU = 4'd6,
		BMI  = 4'd7,
		BPL  = 4'd8,
		BVS  = 4'd9,
		BVC  = 4'd10,
		BGT  = 4'd11,
		BGE  = 4'd12,
		BLE  = 4'd13,
		BLT  = 4'd14
	} cond_e;

	typedef struct packed {
		opcode_e               opcode;
		logic [`REG_BITS-1:0]  ra;
		logic [`REG_BITS-1:0]  rb;
		logic [`REG_BITS-1:0]  rt;
		logic [4:0]            spare;
		funct_e                funct;
	} rr_fmt_t;

	typedef struct packed {
		opcode_e               opcode;
		logic [`REG_BITS-1:0]  ra;
		logic [`REG_BITS-1:0]  rt;
		logic [15:0]           imm;
	} imm_fmt_t;

	// One word decoded two ways by opcode
	typedef union packed {
		rr_fmt_t  rr;
		imm_fmt_t im;
	} insn_u;

endpackage

`default_nettype wire

// ==== rtl/pipe_pkg.sv ====
`include "barrel_consts.svh"
`default_nettype none

package pipe_pkg;

	typedef struct packed {
		logic z;
		logic c;
		logic n;
		logic v;
	} flags_t;

	typedef struct packed {
		logic                  valid;
		logic [`CTX_BITS-1:0]  ctx;
		logic [`XLEN-1:0]      pc;
		logic [`XLEN-1:0]      insn;
	} fetch_t;

	typedef struct packed {
		logic                  valid;
		logic [`CTX_BITS-1:0]  ctx;
		logic [`XLEN-1:0]      pc;
		logic [`XLEN-1:0]      insn;
		logic [`XLEN-1:0]      a;
		logic [`XLEN-1:0]      b;
		flags_t                flags;
	} operand_t;

	typedef struct packed {
		logic                  valid;
		logic [`CTX_BITS-1:0]  ctx;
		logic [`XLEN-1:0]      result;
		logic [`XLEN-1:0]      store_data;
		logic [`REG_BITS-1:0]  rd;
		logic                  we;
		logic                  flag_we;
		flags_t                flags;
		logic                  is_load;
		logic                  is_store;
	} exec_t;

	typedef struct packed {
		logic                  valid;
		logic [`CTX_BITS-1:0]  ctx;
		logic [`REG_BITS-1:0]  rd;
		logic [`XLEN-1:0]      data;
		logic                  we;
		logic                  flag_we;
		flags_t                flags;
	} wb_t;

	typedef struct packed {
		logic                  valid;
		logic [`CTX_BITS-1:0]  ctx;
		logic [`XLEN-1:0]      pc;
	} redirect_t;

endpackage

`default_nettype wire

// ==== rtl/barrel_fetch.sv ====
`include "barrel_consts.svh"
`default_nettype none

module barrel_fetch import pipe_pkg::*; (
	input  wire logic              clk_i,
	input  wire logic              reset_i,
	input  wire logic              stall_i,
	input  wire logic              imem_hit_i,
	input  wire logic [`XLEN-1:0]  imem_dat_i,
	input  wire redirect_t         redirect_i,
	output logic [`XLEN-1:0]       imem_adr_o,
	output fetch_t                 fetch_o
);

	logic [`XLEN-1:0]     pc [`NUM_CTX];
	logic [`CTX_BITS-1:0] ctx;
	logic [`CTX_BITS-1:0] ctx_next;

	assign imem_adr_o = pc[ctx];
	assign ctx_next = (ctx == `CTX_BITS'(`NUM_CTX - 1)) ? '0 : ctx + 1'b1;

	// Per-context PCs, only ever moved by execute
	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			for (int i = 0; i < `NUM_CTX; i++)
				pc[i] <= `XLEN'(i) << `CTX_PC_SHIFT;
		end else if (redirect_i.valid) begin
			pc[redirect_i.ctx] <= redirect_i.pc;
		end
	end

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			ctx <= '0;
			fetch_o.valid <= 1'b0;
		end else if (!stall_i) begin
			fetch_o.ctx <= ctx;
			fetch_o.pc <= pc[ctx];
			if (imem_hit_i) begin
				fetch_o.valid <= 1'b1;
				fetch_o.insn <= imem_dat_i;
				ctx <= ctx_next;
			end else begin
				// A miss sends a bubble and retries the same context
				fetch_o.valid <= 1'b0;
				fetch_o.insn <= `NOP_WORD;
			end
		end
	end

endmodule

`default_nettype wire

// ==== rtl/barrel_operand.sv ====
`include "barrel_consts.svh"
`default_nettype none

module barrel_operand import isa_pkg::*, pipe_pkg::*; (
	input  wire logic      clk_i,
	input  wire logic      reset_i,
	input  wire logic      stall_i,
	input  wire fetch_t    fetch_i,
	input  wire wb_t       wb_i,
	output operand_t       operand_o
);

	insn_u                insn;
	logic [`REG_BITS-1:0] ra;
	logic [`REG_BITS-1:0] rb;
	logic [`XLEN-1:0]     a_val;
	logic [`XLEN-1:0]     b_val;
	operand_t             operand_d;

	// Banked register file indexed by {context, register}
	logic [`XLEN-1:0] regs [`NUM_CTX * `NUM_REGS];
	flags_t           flags [`NUM_CTX];

	// ----------------------------------------
	// Source decode and read
	// ----------------------------------------
	assign insn = fetch_i.insn;
	assign ra = insn.rr.ra;
	// The rt field of SW shares its bits with rb
	assign rb = insn.rr.rb;

	assign a_val = (ra == '0) ? '0 : regs[{fetch_i.ctx, ra}];
	assign b_val = (rb == '0) ? '0 : regs[{fetch_i.ctx, rb}];

	always_comb begin
		operand_d.valid = fetch_i.valid;
		operand_d.ctx = fetch_i.ctx;
		operand_d.pc = fetch_i.pc;
		operand_d.insn = fetch_i.insn;
		operand_d.a = a_val;
		operand_d.b = b_val;
		operand_d.flags = flags[fetch_i.ctx];
	end

	always_ff @(posedge clk_i) begin
		if (reset_i)
			operand_o.valid <= 1'b0;
		else if (!stall_i)
			operand_o <= operand_d;
	end

	// ----------------------------------------
	// Writeback port
	// ----------------------------------------
	// Held writebacks during a stall just rewrite the same value
	always_ff @(posedge clk_i) begin
		if (wb_i.valid && wb_i.we && wb_i.rd != '0)
			regs[{wb_i.ctx, wb_i.rd}] <= wb_i.data;
	end

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			for (int i = 0; i < `NUM_CTX; i++)
				flags[i] <= '0;
		end else if (wb_i.valid && wb_i.flag_we) begin
			flags[wb_i.ctx] <= wb_i.flags;
		end
	end

endmodule

`default_nettype wire

// ==== rtl/barrel_execute.sv ====
`include "barrel_consts.svh"
`default_nettype none

module barrel_execute import isa_pkg::*, pipe_pkg::*; (
	input  wire logic      clk_i,
	input  wire logic      reset_i,
	input  wire logic      stall_i,
	input  wire operand_t  operand_i,
	output exec_t          exec_o,
	output redirect_t      redirect_o
);

	localparam int MSB = `XLEN - 1;

	insn_u                insn;
	opcode_e              op;
	funct_e               fn;
	flags_t               fin;
	flags_t               fout;
	logic [`XLEN-1:0]     a;
	logic [`XLEN-1:0]     alu_b;
	logic [`XLEN-1:0]     imm_sx;
	logic [`XLEN-1:0]     imm_zx;
	logic [`XLEN-1:0]     result;
	logic [`XLEN-1:0]     pc_seq;
	logic [`XLEN-1:0]     ctx_base;
	logic [`XLEN-1:0]     next_pc;
	logic [`XLEN:0]       sum;
	logic                 is_alu;
	logic                 take;
	exec_t                exec_d;
	redirect_t            redirect_d;

	assign insn = operand_i.insn;
	assign op = insn.rr.opcode;
	assign fin = operand_i.flags;
	assign a = operand_i.a;
	assign imm_sx = {{(`XLEN - 16){insn.im.imm[15]}}, insn.im.imm};
	assign imm_zx = {{(`XLEN - 16){1'b0}}, insn.im.imm};
	assign alu_b = (op == RR) ? operand_i.b : imm_sx;

	// Immediate forms share the RR function codes; LW/SW compute an address
	always_comb begin
		is_alu = 1'b1;
		case (op)
			RR: begin
				fn = insn.rr.funct;
				is_alu = insn.rr.funct inside {ADD, SUB, AND, OR, XOR, CMP};
			end
			ADDI: fn = ADD;
			SUBI: fn = SUB;
			ANDI: fn = AND;
			ORI:  fn = OR;
			XORI: fn = XOR;
			CMPI: fn = CMP;
			default: begin
				fn = ADD;
				is_alu = 1'b0;
			end
		endcase
	end

	// ----------------------------------------
	// ALU and flags
	// ----------------------------------------
	always_comb begin
		case (fn)
			SUB, CMP: sum = {1'b0, a} - {1'b0, alu_b};
			AND:      sum = {1'b0, a & alu_b};
			OR:       sum = {1'b0, a | alu_b};
			XOR:      sum = {1'b0, a ^ alu_b};
			default:  sum = {1'b0, a} + {1'b0, alu_b};
		endcase
		result = sum[`XLEN-1:0];

		fout = fin;
		if (is_alu) begin
			fout.z = (result == '0);
			fout.n = result[MSB];
			// Logic ops keep C and V
			if (fn == ADD) begin
				fout.c = sum[`XLEN];
				fout.v = (a[MSB] == alu_b[MSB]) && (result[MSB] != a[MSB]);
			end else if (fn == SUB || fn == CMP) begin
				fout.c = sum[`XLEN];
				fout.v = (a[MSB] != alu_b[MSB]) && (result[MSB] != a[MSB]);
			end
		end
	end

	// ----------------------------------------
	// Branch condition and next PC
	// ----------------------------------------
	always_comb begin
		case (cond_e'(insn.im.ra[3:0]))
			BRA:     take = 1'b1;
			BEQ:     take = fin.z;
			BNE:     take = !fin.z;
			BGTU:    take = !fin.c && !fin.z;
			BLEU:    take = fin.c || fin.z;
			BLTU:    take = fin.c;
			BGEU:    take = !fin.c;
			BMI:     take = fin.n;
			BPL:     take = !fin.n;
			BVS:     take = fin.v;
			BVC:     take = !fin.v;
			BGT:     take = (fin.n == fin.v) && !fin.z;
			BGE:     take = (fin.n == fin.v);
			BLE:     take = fin.z || (fin.n != fin.v);
			BLT:     take = (fin.n != fin.v);
			default: take = 1'b0;
		endcase
	end

	assign pc_seq = operand_i.pc + `XLEN'(4);
	assign ctx_base = `XLEN'(operand_i.ctx) << `CTX_PC_SHIFT;

	always_comb begin
		if (op == JMP)
			next_pc = ctx_base + (imm_zx << 2);
		else if (op == BCC && take)
			next_pc = pc_seq + (imm_sx << 2);
		else
			next_pc = pc_seq;
	end

	always_comb begin
		exec_d.valid = operand_i.valid;
		exec_d.ctx = operand_i.ctx;
		exec_d.result = result;
		exec_d.store_data = operand_i.b;
		exec_d.rd = (op == RR) ? insn.rr.rt : insn.im.rt;
		exec_d.we = (is_alu && fn != CMP) || op == LW;
		exec_d.flag_we = is_alu;
		exec_d.flags = fout;
		exec_d.is_load = (op == LW);
		exec_d.is_store = (op == SW);

		redirect_d.valid = operand_i.valid;
		redirect_d.ctx = operand_i.ctx;
		redirect_d.pc = next_pc;
	end

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			exec_o.valid <= 1'b0;
			redirect_o.valid <= 1'b0;
		end else if (!stall_i) begin
			exec_o <= exec_d;
			redirect_o <= redirect_d;
		end
	end

endmodule

`default_nettype wire

// ==== rtl/barrel_memory.sv ====
`include "barrel_consts.svh"
`default_nettype none

module barrel_memory import pipe_pkg::*; (
	input  wire logic              clk_i,
	input  wire logic              reset_i,
	input  wire exec_t             exec_i,
	input  wire logic              dbus_ack_i,
	input  wire logic [`XLEN-1:0]  dbus_dat_i,
	output logic                   dbus_cyc_o,
	output logic                   dbus_stb_o,
	output logic                   dbus_we_o,
	output logic [`XLEN-1:0]       dbus_adr_o,
	output logic [`XLEN-1:0]       dbus_dat_o,
	output logic                   stall_o,
	output wb_t                    wb_o
);

	typedef enum logic {
		S_IDLE,
		S_BUSY
	} state_e;

	state_e state;
	logic   mem_op;
	flags_t load_flags;
	wb_t    wb_d;

	assign mem_op = exec_i.valid && (exec_i.is_load || exec_i.is_store);

	// Freeze everything until the access is acknowledged
	assign stall_o = mem_op && !(state == S_BUSY && dbus_ack_i);

	// ----------------------------------------
	// Bus master
	// ----------------------------------------
	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			state <= S_IDLE;
			dbus_cyc_o <= 1'b0;
			dbus_stb_o <= 1'b0;
			dbus_we_o <= 1'b0;
		end else begin
			case (state)
				S_IDLE:
					if (mem_op) begin
						state <= S_BUSY;
						dbus_cyc_o <= 1'b1;
						dbus_stb_o <= 1'b1;
						dbus_we_o <= exec_i.is_store;
					end
				S_BUSY:
					if (dbus_ack_i) begin
						state <= S_IDLE;
						dbus_cyc_o <= 1'b0;
						dbus_stb_o <= 1'b0;
						dbus_we_o <= 1'b0;
					end
				default:
					state <= S_IDLE;
			endcase
		end
	end

	// Address and data latched as the cycle opens
	always_ff @(posedge clk_i) begin
		if (state == S_IDLE && mem_op) begin
			dbus_adr_o <= exec_i.result;
			dbus_dat_o <= exec_i.store_data;
		end
	end

	// ----------------------------------------
	// Writeback record
	// ----------------------------------------
	always_comb begin
		load_flags = exec_i.flags;
		load_flags.z = (dbus_dat_i == '0);
		load_flags.n = dbus_dat_i[`XLEN-1];

		wb_d.valid = exec_i.valid;
		wb_d.ctx = exec_i.ctx;
		wb_d.rd = exec_i.rd;
		wb_d.we = exec_i.we;
		wb_d.data = exec_i.is_load ? dbus_dat_i : exec_i.result;
		wb_d.flag_we = exec_i.flag_we || exec_i.is_load;
		wb_d.flags = exec_i.is_load ? load_flags : exec_i.flags;
	end

	always_ff @(posedge clk_i) begin
		if (reset_i)
			wb_o.valid <= 1'b0;
		else if (!stall_o)
			wb_o <= wb_d;
	end

endmodule

`default_nettype wire

// ==== rtl/barrel_core.sv ====
`include "barrel_consts.svh"
`default_nettype none

module barrel_core import pipe_pkg::*; (
	input  wire logic              clk_i,
	input  wire logic              reset_i,
	// Instruction port
	output logic [`XLEN-1:0]       imem_adr_o,
	input  wire logic [`XLEN-1:0]  imem_dat_i,
	input  wire logic              imem_hit_i,
	// Data bus
	output logic                   dbus_cyc_o,
	output logic                   dbus_stb_o,
	output logic                   dbus_we_o,
	output logic [`XLEN-1:0]       dbus_adr_o,
	output logic [`XLEN-1:0]       dbus_dat_o,
	input  wire logic [`XLEN-1:0]  dbus_dat_i,
	input  wire logic              dbus_ack_i
);

	fetch_t    fetch_w;
	operand_t  operand_w;
	exec_t     exec_w;
	wb_t       wb_w;
	redirect_t redirect_w;
	logic      stall_w;

	barrel_fetch fetch0 (
		.clk_i      (clk_i),
		.reset_i    (reset_i),
		.stall_i    (stall_w),
		.imem_hit_i (imem_hit_i),
		.imem_dat_i (imem_dat_i),
		.redirect_i (redirect_w),
		.imem_adr_o (imem_adr_o),
		.fetch_o    (fetch_w)
	);

	barrel_operand operand0 (
		.clk_i     (clk_i),
		.reset_i   (reset_i),
		.stall_i   (stall_w),
		.fetch_i   (fetch_w),
		.wb_i      (wb_w),
		.operand_o (operand_w)
	);

	barrel_execute execute0 (
		.clk_i      (clk_i),
		.reset_i    (reset_i),
		.stall_i    (stall_w),
		.operand_i  (operand_w),
		.exec_o     (exec_w),
		.redirect_o (redirect_w)
	);

	barrel_memory memory0 (
		.clk_i      (clk_i),
		.reset_i    (reset_i),
		.exec_i     (exec_w),
		.dbus_ack_i (dbus_ack_i),
		.dbus_dat_i (dbus_dat_i),
		.dbus_cyc_o (dbus_cyc_o),
		.dbus_stb_o (dbus_stb_o),
		.dbus_we_o  (dbus_we_o),
		.dbus_adr_o (dbus_adr_o),
		.dbus_dat_o (dbus_dat_o),
		.stall_o    (stall_w),
		.wb_o       (wb_w)
	);

endmodule

`default_nettype wire

// ==== verification/barrel_assertions.sv ====
`include "barrel_consts.svh"
`default_nettype none

module barrel_assertions (
	input wire logic              clk_i,
	input wire logic              reset_i,
	input wire logic              stall_i,
	input wire logic              dbus_cyc_i,
	input wire logic              dbus_stb_i,
	input wire logic              dbus_we_i,
	input wire logic              dbus_ack_i,
	input wire logic [`XLEN-1:0]  dbus_adr_i,
	input wire logic [`XLEN-1:0]  dbus_dat_i,
	input wire logic [`XLEN-1:0]  imem_adr_i
);

	// Request stays up until acknowledged
	stb_hold: assert property (@(posedge clk_i) disable iff (reset_i)
		dbus_stb_i && !dbus_ack_i |=> dbus_stb_i && dbus_cyc_i)
		else $error("dbus strobe dropped before ack");

	req_stable: assert property (@(posedge clk_i) disable iff (reset_i)
		dbus_stb_i && !dbus_ack_i |=>
			$stable(dbus_adr_i) && $stable(dbus_we_i) && $stable(dbus_dat_i))
		else $error("dbus request changed before ack");

	cyc_release: assert property (@(posedge clk_i) disable iff (reset_i)
		dbus_cyc_i && dbus_ack_i |=> !dbus_cyc_i)
		else $error("dbus cyc still high after ack");

	// Frozen fetch keeps its address
	fetch_hold: assert property (@(posedge clk_i) disable iff (reset_i)
		stall_i |=> $stable(imem_adr_i))
		else $error("instruction address moved during a stall");

endmodule

bind barrel_core barrel_assertions assertions0 (
	.clk_i      (clk_i),
	.reset_i    (reset_i),
	.stall_i    (stall_w),
	.dbus_cyc_i (dbus_cyc_o),
	.dbus_stb_i (dbus_stb_o),
	.dbus_we_i  (dbus_we_o),
	.dbus_ack_i (dbus_ack_i),
	.dbus_adr_i (dbus_adr_o),
	.dbus_dat_i (dbus_dat_o),
	.imem_adr_i (imem_adr_o)
);

`default_nettype wire

// ==== verification/barrel_tb.sv ====
`include "barrel_consts.svh"
`default_nettype none

module barrel_tb import isa_pkg::*; ();

	localparam logic [`XLEN-1:0] DATA_BASE = 32'h4000;
	localparam logic [`XLEN-1:0] TABLE_BASE = 32'h6000;
	localparam int WORDS_PER_CTX = 1 << (`CTX_PC_SHIFT - 2);
	localparam int IMEM_WORDS = `NUM_CTX * WORDS_PER_CTX;
	localparam int TIMEOUT = 20000;

	logic             clk_i;
	logic             reset_i;
	logic [`XLEN-1:0] imem_adr;
	logic [`XLEN-1:0] imem_dat;
	logic             imem_hit = 1'b1;
	logic             dbus_cyc;
	logic             dbus_stb;
	logic             dbus_we;
	logic             dbus_ack = 1'b0;
	logic [`XLEN-1:0] dbus_adr;
	logic [`XLEN-1:0] dbus_wdata;
	logic [`XLEN-1:0] dbus_rdata = '0;

	logic [`XLEN-1:0] imem [IMEM_WORDS];
	logic [`XLEN-1:0] dmem [logic [`XLEN-1:0]];
	// Expected stores in program order for each context
	logic [`XLEN-1:0] exp_adr [`NUM_CTX][$];
	logic [`XLEN-1:0] exp_dat [`NUM_CTX][$];
	int               prog_len [`NUM_CTX];

	int xfer_count = 0;
	int ack_wait = 0;
	int bus_errors = 0;
	int store_checks = 0;
	int errors;
	int count_checks;
	int miss_pct;
	int max_ack_delay;

	initial begin
		clk_i = 1'b0;
		forever #2 clk_i = ~clk_i;
	end

	barrel_core dut0 (
		.clk_i      (clk_i),
		.reset_i    (reset_i),
		.imem_adr_o (imem_adr),
		.imem_dat_i (imem_dat),
		.imem_hit_i (imem_hit),
		.dbus_cyc_o (dbus_cyc),
		.dbus_stb_o (dbus_stb),
		.dbus_we_o  (dbus_we),
		.dbus_adr_o (dbus_adr),
		.dbus_dat_o (dbus_wdata),
		.dbus_dat_i (dbus_rdata),
		.dbus_ack_i (dbus_ack)
	);

	// ----------------------------------------
	// Memory models
	// ----------------------------------------
	assign imem_dat = imem[imem_adr[`CTX_BITS + `CTX_PC_SHIFT - 1:2]];

	always @(negedge clk_i) begin
		if (miss_pct == 0)
			imem_hit = 1'b1;
		else
			imem_hit = (int'($urandom_range(99, 0)) >= miss_pct);
	end

	// Data slave acks after a random number of wait cycles
	always @(negedge clk_i) begin
		if (dbus_ack) begin
			dbus_ack = 1'b0;
		end else if (dbus_cyc && dbus_stb) begin
			if (ack_wait == 0) begin
				serve_access();
				dbus_ack = 1'b1;
				ack_wait = int'($urandom_range(max_ack_delay, 0));
			end else begin
				ack_wait--;
			end
		end
	end

	function automatic logic [`XLEN-1:0] read_word(logic [`XLEN-1:0] adr);
		if (dmem.exists(adr))
			return dmem[adr];
		return {~adr[15:0], adr[31:16]} ^ 32'h3c3c_a5a5;
	endfunction

	function automatic int ctx_of(logic [`XLEN-1:0] adr);
		if (adr < DATA_BASE || adr >= DATA_BASE + (`NUM_CTX << 8))
			return -1;
		return int'((adr - DATA_BASE) >> 8);
	endfunction

	task automatic serve_access();
		int c;
		c = ctx_of(dbus_adr);
		xfer_count++;
		if (!dbus_we) begin
			dbus_rdata = read_word(dbus_adr);
		end else begin
			dmem[dbus_adr] = dbus_wdata;
			if (c < 0 || exp_adr[c].size() == 0) begin
				bus_errors++;
				$display("Store of %h to %h was not expected", dbus_wdata, dbus_adr);
			end else begin
				check_store(exp_adr[c].pop_front(), exp_dat[c].pop_front(), dbus_adr, dbus_wdata);
			end
		end
	endtask

	// ----------------------------------------
	// Compare tasks
	// ----------------------------------------
	task automatic check_store(logic [`XLEN-1:0] exp_a, logic [`XLEN-1:0] exp_d,
			logic [`XLEN-1:0] act_a, logic [`XLEN-1:0] act_d);
		store_checks++;
		if (act_a !== exp_a) begin
			bus_errors++;
			$display("FAIL dbus_adr_o: expected %h, got %h", exp_a, act_a);
		end
		if (act_d !== exp_d) begin
			bus_errors++;
			$display("FAIL dbus_dat_o: expected %h, got %h (address %h)", exp_d, act_d, act_a);
		end
	endtask

	task automatic check_count(int exp_n, int act_n);
		count_checks++;
		if (act_n != exp_n) begin
			errors++;
			$display("FAIL xfer_count: expected %h, got %h", exp_n, act_n);
		end
	endtask

	// ----------------------------------------
	// Assembler and reference model
	// ----------------------------------------
	function automatic logic [`XLEN-1:0] rr_word(funct_e fn, int rt, int ra, int rb);
		insn_u w;
		w = '0;
		w.rr.opcode = RR;
		w.rr.ra = `REG_BITS'(ra);
		w.rr.rb = `REG_BITS'(rb);
		w.rr.rt = `REG_BITS'(rt);
		w.rr.funct = fn;
		return w;
	endfunction

	function automatic logic [`XLEN-1:0] imm_word(opcode_e op, int rt, int ra, int imm);
		insn_u w;
		w = '0;
		w.im.opcode = op;
		w.im.ra = `REG_BITS'(ra);
		w.im.rt = `REG_BITS'(rt);
		w.im.imm = 16'(imm);
		return w;
	endfunction

	function automatic logic [`XLEN-1:0] branch_word(cond_e cc, int off);
		insn_u w;
		w = '0;
		w.im.opcode = BCC;
		w.im.ra = `REG_BITS'(cc);
		w.im.imm = 16'(off);
		return w;
	endfunction

	function automatic logic [`XLEN-1:0] jmp_word(int off);
		insn_u w;
		w = '0;
		w.im.opcode = JMP;
		w.im.imm = 16'(off);
		return w;
	endfunction

	function automatic logic [`XLEN-1:0] sext16(int v);
		logic [15:0] h;
		h = 16'(v);
		return {{(`XLEN - 16){h[15]}}, h};
	endfunction

	function automatic logic [`XLEN-1:0] alu_ref(funct_e fn, logic [`XLEN-1:0] x,
			logic [`XLEN-1:0] y);
		case (fn)
			ADD: return x + y;
			SUB: return x - y;
			AND: return x & y;
			OR:  return x | y;
			default: return x ^ y;
		endcase
	endfunction

	// Outcome of a branch after CMP x,y from plain comparisons
	function automatic logic branch_ref(cond_e cc, logic [`XLEN-1:0] x, logic [`XLEN-1:0] y);
		logic [`XLEN-1:0] d;
		longint           exact;
		logic             ovf;
		d = x - y;
		// Signed overflow when the wrapped difference differs from the exact one
		exact = longint'($signed(x)) - longint'($signed(y));
		ovf = (exact != longint'($signed(d)));
		case (cc)
			BRA:  return 1'b1;
			BEQ:  return x == y;
			BNE:  return x != y;
			BGTU: return x > y;
			BLEU: return x <= y;
			BLTU: return x < y;
			BGEU: return x >= y;
			BMI:  return d[`XLEN-1];
			BPL:  return !d[`XLEN-1];
			BVS:  return ovf;
			BVC:  return !ovf;
			BGT:  return $signed(x) > $signed(y);
			BGE:  return $signed(x) >= $signed(y);
			BLE:  return $signed(x) <= $signed(y);
			default: return $signed(x) < $signed(y);
		endcase
	endfunction

	function automatic logic [`XLEN-1:0] store_addr(int c, int slot);
		return DATA_BASE + `XLEN'(c * 256 + slot * 4);
	endfunction

	task automatic emit(int c, logic [`XLEN-1:0] w);
		imem[c * WORDS_PER_CTX + prog_len[c]] = w;
		prog_len[c]++;
	endtask

	task automatic expect_store(int c, logic [`XLEN-1:0] adr, logic [`XLEN-1:0] dat);
		exp_adr[c].push_back(adr);
		exp_dat[c].push_back(dat);
	endtask

	// ----------------------------------------
	// Test sequencing
	// ----------------------------------------
	task automatic begin_test(int pct, int delay);
		@(negedge clk_i);
		reset_i = 1'b1;
		miss_pct = pct;
		max_ack_delay = delay;
		dmem.delete();
		for (int c = 0; c < `NUM_CTX; c++) begin
			exp_adr[c].delete();
			exp_dat[c].delete();
			prog_len[c] = 0;
		end
		// Unused words jump to themselves
		for (int i = 0; i < IMEM_WORDS; i++)
			imem[i] = jmp_word(i % WORDS_PER_CTX);
	endtask

	task automatic run_program(int n_xfers, string name);
		int base;
		int waited;
		repeat (8) @(negedge clk_i);
		base = xfer_count;
		reset_i = 1'b0;
		waited = 0;
		while (xfer_count - base < n_xfers && waited < TIMEOUT) begin
			@(negedge clk_i);
			waited++;
		end
		if (xfer_count - base < n_xfers) begin
			errors++;
			$display("Timeout in %s test after %0d of %0d bus transfers", name,
				xfer_count - base, n_xfers);
		end
		// Time for any extra transfer to show up
		repeat (6 * `NUM_CTX) @(negedge clk_i);
		check_count(n_xfers, xfer_count - base);
		for (int c = 0; c < `NUM_CTX; c++) begin
			if (exp_adr[c].size() != 0) begin
				errors++;
				$display("Context %0d never made %0d of its stores in %s test", c,
					exp_adr[c].size(), name);
			end
		end
	endtask

	task automatic test_alu(int pct, int delay);
		funct_e           fns [5] = '{ADD, SUB, AND, OR, XOR};
		opcode_e          imms [5] = '{ADDI, SUBI, ANDI, ORI, XORI};
		logic [`XLEN-1:0] av;
		logic [`XLEN-1:0] bv;
		int               a16;
		int               b16;
		int               i16;
		begin_test(pct, delay);
		for (int c = 0; c < `NUM_CTX; c++) begin
			a16 = int'($urandom_range(65535, 0));
			b16 = int'($urandom_range(65535, 0));
			av = sext16(a16);
			bv = sext16(b16);
			emit(c, imm_word(ADDI, 1, 0, a16));
			emit(c, imm_word(ADDI, 2, 0, b16));
			for (int j = 0; j < 5; j++) begin
				emit(c, rr_word(fns[j], 3, 1, 2));
				emit(c, imm_word(SW, 3, 0, int'(store_addr(c, j))));
				expect_store(c, store_addr(c, j), alu_ref(fns[j], av, bv));
			end
			for (int j = 0; j < 5; j++) begin
				i16 = int'($urandom_range(65535, 0));
				emit(c, imm_word(imms[j], 3, 1, i16));
				emit(c, imm_word(SW, 3, 0, int'(store_addr(c, 5 + j))));
				expect_store(c, store_addr(c, 5 + j), alu_ref(fns[j], av, sext16(i16)));
			end
			emit(c, jmp_word(prog_len[c]));
		end
		run_program(10 * `NUM_CTX, "ALU");
	endtask

	task automatic test_branch(int pct, int delay);
		logic [`XLEN-1:0] lhs [6] = '{32'd5, 32'd3, 32'd7, 32'h7fff_ffff, 32'h8000_0000,
			32'hffff_ffff};
		logic [`XLEN-1:0] rhs [6] = '{32'd5, 32'd7, 32'd3, 32'hffff_ffff, 32'd1, 32'd1};
		cond_e            cc;
		int               slot;
		int               n_xfers;
		begin_test(pct, delay);
		n_xfers = 0;
		for (int p = 0; p < 6; p++) begin
			dmem[TABLE_BASE + `XLEN'(p * 8)] = lhs[p];
			dmem[TABLE_BASE + `XLEN'(p * 8 + 4)] = rhs[p];
		end
		for (int c = 0; c < `NUM_CTX; c++) begin
			slot = 0;
			for (int p = 0; p < 6; p++) begin
				emit(c, imm_word(LW, 1, 0, int'(TABLE_BASE) + p * 8));
				emit(c, imm_word(LW, 2, 0, int'(TABLE_BASE) + p * 8 + 4));
				n_xfers += 2;
				// Taken path keeps the first marker
				for (int k = c; k < 15; k += 8) begin
					cc = cond_e'(k);
					emit(c, imm_word(ORI, 3, 0, 256 + k));
					emit(c, rr_word(CMP, 0, 1, 2));
					emit(c, branch_word(cc, 1));
					emit(c, imm_word(ORI, 3, 0, 512 + k));
					emit(c, imm_word(SW, 3, 0, int'(store_addr(c, slot))));
					expect_store(c, store_addr(c, slot),
						branch_ref(cc, lhs[p], rhs[p]) ? 32'(256 + k) : 32'(512 + k));
					slot++;
					n_xfers++;
				end
			end
			emit(c, jmp_word(prog_len[c]));
		end
		run_program(n_xfers, "branch");
	endtask

	task automatic test_loop();
		int cnt;
		int step;
		begin_test(0, 1);
		for (int c = 0; c < `NUM_CTX; c++) begin
			cnt = c + 3;
			step = 7 + 5 * c;
			emit(c, imm_word(ORI, 1, 0, 0));
			emit(c, imm_word(ADDI, 2, 0, cnt));
			emit(c, imm_word(ADDI, 1, 1, step));
			emit(c, imm_word(SUBI, 2, 2, 1));
			emit(c, branch_word(BEQ, 1));
			emit(c, jmp_word(2));
			emit(c, imm_word(SW, 1, 0, int'(store_addr(c, 0))));
			emit(c, imm_word(SW, 2, 0, int'(store_addr(c, 1))));
			emit(c, jmp_word(prog_len[c]));
			expect_store(c, store_addr(c, 0), 32'(cnt * step));
			expect_store(c, store_addr(c, 1), '0);
		end
		run_program(2 * `NUM_CTX, "loop");
	endtask

	task automatic test_load_store();
		logic [`XLEN-1:0] d;
		logic [`XLEN-1:0] v1;
		int               k;
		int               x;
		begin_test(0, 4);
		for (int c = 0; c < `NUM_CTX; c++) begin
			d = $urandom;
			k = int'($urandom_range(65535, 0));
			x = int'($urandom_range(65535, 0));
			dmem[store_addr(c, 0)] = d;
			v1 = d + sext16(k);
			emit(c, imm_word(LW, 1, 0, int'(store_addr(c, 0))));
			emit(c, imm_word(ADDI, 1, 1, k));
			emit(c, imm_word(SW, 1, 0, int'(store_addr(c, 1))));
			emit(c, imm_word(LW, 2, 0, int'(store_addr(c, 1))));
			emit(c, imm_word(XORI, 2, 2, x));
			emit(c, imm_word(SW, 2, 0, int'(store_addr(c, 2))));
			emit(c, jmp_word(prog_len[c]));
			expect_store(c, store_addr(c, 1), v1);
			expect_store(c, store_addr(c, 2), v1 ^ sext16(x));
		end
		run_program(4 * `NUM_CTX, "load/store");
	endtask

	initial begin
		void'($urandom(32'he763e113));
		reset_i = 1'b1;
		errors = 0;
		count_checks = 0;
		miss_pct = 0;
		max_ack_delay = 0;
		test_alu(0, 0);
		test_branch(0, 1);
		test_loop();
		test_load_store();
		// Same programs again with instruction misses
		test_alu(30, 2);
		test_branch(25, 3);
		errors += bus_errors;
		$display("Checks: %0d, errors: %0d", store_checks + count_checks, errors);
		if (errors == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+include
rtl/isa_pkg.sv
rtl/pipe_pkg.sv
rtl/barrel_fetch.sv
rtl/barrel_operand.sv
rtl/barrel_execute.sv
rtl/barrel_memory.sv
rtl/barrel_core.sv
verification/barrel_assertions.sv
verification/barrel_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= barrel_tb
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f all.f --top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); test $$status -eq 0
	! grep -q "Verification failed" $(LOG)
	grep -q "Verification passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
